// File: srt_div_pkg.sv
package srt_div_pkg;

  // widths of the datapath
  localparam int MAN_W   = 24;    // significand incl. hidden bit
  localparam int RESID_W = 28;    // shifted residual 4w, two's complement
  localparam int QUO_W   = 28;    // two quotient bits per step
  localparam int N_ITER  = 14;    // radix-4 steps
  localparam int EXP_W   = 10;    // signed internal exponent
  localparam int LATENCY = 16;    // start edge to done edge
  localparam int CNT_W   = $clog2(LATENCY);

  // exponent limits, biased
  localparam logic signed [EXP_W-1:0] EXP_BIAS = 127;
  localparam logic signed [EXP_W-1:0] EXP_MAX  = 255;   // first exponent that overflows

  localparam logic [31:0] QNAN = 32'h7fc0_0000;   // canonical quiet nan

  typedef struct packed {
    logic       sign;
    logic [7:0] exp;
    logic [22:0] frac;
  } fp32_fields_s;

  // one port word, read raw or by field
  typedef union packed {
    logic [31:0]  word;
    fp32_fields_s f;
  } fp32_u;

  // result class decided before the recurrence
  typedef enum logic [1:0] {
    SP_NONE,
    SP_NAN,
    SP_INF,
    SP_ZERO
  } special_e;

  typedef struct packed {
    logic invalid;
    logic div_by_zero;
    logic overflow;
    logic underflow;
    logic inexact;
  } div_flags_s;

  typedef struct packed {
    logic                    sign;       // xor of operand signs
    logic signed [EXP_W-1:0] exp_base;   // ea - eb + bias
    special_e                special;
    div_flags_s              early;      // invalid / div_by_zero only
  } op_info_s;

  // handed from the recurrence to round/pack
  typedef struct packed {
    logic [QUO_W-1:0] quo;     // corrected quotient, value quo / 2^25
    logic             sticky;  // final remainder nonzero
    op_info_s         info;
  } iter_res_s;

  // one signed radix-4 digit, -2..+2
  typedef struct packed {
    logic       neg;
    logic [1:0] mag;
  } qdigit_s;

endpackage

// File: srt_unpack.sv
`timescale 1ns/100ps

module srt_unpack (
  input  srt_div_pkg::fp32_u                 a,
  input  srt_div_pkg::fp32_u                 b,
  output srt_div_pkg::op_info_s              info,
  output logic [srt_div_pkg::MAN_W-1:0]      man_a,
  output logic [srt_div_pkg::MAN_W-1:0]      man_b
);
  import srt_div_pkg::*;

  logic a_nan, a_inf, a_zero;
  logic b_nan, b_inf, b_zero;
  logic signed [EXP_W-1:0] ea, eb;

  // operand classes, subnormals count as zero
  assign a_nan  = (a.f.exp == 8'hff) && (a.f.frac != '0);
  assign a_inf  = (a.f.exp == 8'hff) && (a.f.frac == '0);
  assign a_zero = (a.f.exp == 8'h00);
  assign b_nan  = (b.f.exp == 8'hff) && (b.f.frac != '0);
  assign b_inf  = (b.f.exp == 8'hff) && (b.f.frac == '0);
  assign b_zero = (b.f.exp == 8'h00);

  assign ea = $signed({{(EXP_W-8){1'b0}}, a.f.exp});
  assign eb = $signed({{(EXP_W-8){1'b0}}, b.f.exp});

  // hidden bit always attached, specials discard the quotient anyway
  assign man_a = {1'b1, a.f.frac};
  assign man_b = {1'b1, b.f.frac};

  always_comb begin
    info          = '0;
    info.sign     = a.f.sign ^ b.f.sign;
    info.exp_base = ea - eb + EXP_BIAS;   // biased exponent before normalization
    info.special  = SP_NONE;
    // priority: nan in, invalid, inf, div by zero, zero
    if (a_nan || b_nan) begin
      info.special = SP_NAN;
    end else if ((a_zero && b_zero) || (a_inf && b_inf)) begin
      info.special       = SP_NAN;
      info.early.invalid = 1'b1;   // 0/0, inf/inf
    end else if (a_inf) begin
      info.special = SP_INF;        // inf / finite
    end else if (b_zero) begin
      info.special           = SP_INF;
      info.early.div_by_zero = 1'b1;   // finite nonzero / 0
    end else if (a_zero || b_inf) begin
      info.special = SP_ZERO;       // 0/x, x/inf
    end
  end

endmodule

// File: srt_qds.sv
`timescale 1ns/100ps

module srt_qds (
  input  logic [6:0]          resid_est,  // floor(8 * 4w), signed
  input  logic [2:0]          d_idx,      // divisor bits after the leading one
  output srt_div_pkg::qdigit_s digit
);

  logic signed [6:0] est;
  logic signed [6:0] th_p2, th_p1, th_z, th_n1;   // thresholds, units of 1/8

  assign est = $signed(resid_est);

  // selection constants m2, m1, m0, m-1 per divisor interval [1/2 + i/16, +1/16)
  always_comb begin
    case (d_idx)
      3'd0: begin
        th_p2 = 7'sd6;   th_p1 = 7'sd2;  th_z = -7'sd2;  th_n1 = -7'sd6;
      end
      3'd1: begin
        th_p2 = 7'sd7;   th_p1 = 7'sd2;  th_z = -7'sd2;  th_n1 = -7'sd7;
      end
      3'd2: begin
        th_p2 = 7'sd8;   th_p1 = 7'sd2;  th_z = -7'sd2;  th_n1 = -7'sd8;
      end
      3'd3: begin
        th_p2 = 7'sd8;   th_p1 = 7'sd2;  th_z = -7'sd2;  th_n1 = -7'sd8;
      end
      3'd4: begin
        th_p2 = 7'sd9;   th_p1 = 7'sd3;  th_z = -7'sd3;  th_n1 = -7'sd9;
      end
      3'd5: begin
        th_p2 = 7'sd10;  th_p1 = 7'sd3;  th_z = -7'sd3;  th_n1 = -7'sd10;
      end
      3'd6: begin
        th_p2 = 7'sd10;  th_p1 = 7'sd3;  th_z = -7'sd3;  th_n1 = -7'sd10;
      end
      default: begin   // d in [15/16, 1)
        th_p2 = 7'sd11;  th_p1 = 7'sd3;  th_z = -7'sd3;  th_n1 = -7'sd11;
      end
    endcase
  end

  // compare against the staircase, largest digit first
  always_comb begin
    if (est >= th_p2) begin
      digit = '{neg: 1'b0, mag: 2'd2};
    end else if (est >= th_p1) begin
      digit = '{neg: 1'b0, mag: 2'd1};
    end else if (est >= th_z) begin
      digit = '{neg: 1'b0, mag: 2'd0};
    end else if (est >= th_n1) begin
      digit = '{neg: 1'b1, mag: 2'd1};
    end else begin
      digit = '{neg: 1'b1, mag: 2'd2};
    end
  end

endmodule

// File: srt_iter.sv
`timescale 1ns/100ps

module srt_iter (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            start,
  input  srt_div_pkg::op_info_s           info,
  input  logic [srt_div_pkg::MAN_W-1:0]   man_a,
  input  logic [srt_div_pkg::MAN_W-1:0]   man_b,
  output logic                            busy,
  output srt_div_pkg::iter_res_s          res,
  output logic                            iter_done
);
  import srt_div_pkg::*;

  logic [CNT_W-1:0]   cnt;
  logic [RESID_W-1:0] resid;      // 4w: sign, 2 int bits, 25 frac bits
  logic [MAN_W-1:0]   dvsr;       // d = dvsr / 2^24, in [1/2, 1)
  logic [QUO_W-1:0]   q_reg, qm_reg;   // on-the-fly pair, qm = q - 1
  logic [QUO_W-1:0]   q_nxt, qm_nxt;
  logic [RESID_W-1:0] mult;       // |digit| * d
  logic [RESID_W-1:0] w_nxt;      // 4w - digit * d
  logic [RESID_W-1:0] resid_sel;  // residual after sign correction
  qdigit_s            digit;
  logic               load, step, fix;

  assign load = start & ~busy;                       // start while busy dropped
  assign step = busy & (cnt < CNT_W'(N_ITER));
  assign fix  = busy & (cnt == CNT_W'(N_ITER));      // correction cycle

  srt_qds u_qds (
    .resid_est ({resid[RESID_W-1], resid[RESID_W-1 -: 6]}),  // sign ext, 3 frac bits
    .d_idx     (dvsr[MAN_W-2 -: 3]),
    .digit     (digit)
  );

  always_comb begin
    case (digit.mag)
      2'd1:    mult = {3'b000, dvsr, 1'b0};   // d
      2'd2:    mult = {2'b00, dvsr, 2'b00};   // 2d
      default: mult = '0;
    endcase
  end

  // negative digit adds, positive digit adds the complement with carry in
  assign w_nxt = digit.neg ? resid + mult : resid + ~mult + RESID_W'(1);

  // negative final residual: take qm and add d back (4d in these units)
  assign resid_sel = resid[RESID_W-1] ? resid + {1'b0, dvsr, 3'b000} : resid;

  // on-the-fly conversion, no carry chain
  always_comb begin
    case ({digit.neg, digit.mag})
      3'b0_01: begin q_nxt = {q_reg[QUO_W-3:0], 2'd1};  qm_nxt = {q_reg[QUO_W-3:0], 2'd0};  end
      3'b0_10: begin q_nxt = {q_reg[QUO_W-3:0], 2'd2};  qm_nxt = {q_reg[QUO_W-3:0], 2'd1};  end
      3'b1_01: begin q_nxt = {qm_reg[QUO_W-3:0], 2'd3}; qm_nxt = {qm_reg[QUO_W-3:0], 2'd2}; end
      3'b1_10: begin q_nxt = {qm_reg[QUO_W-3:0], 2'd2}; qm_nxt = {qm_reg[QUO_W-3:0], 2'd1}; end
      default: begin q_nxt = {q_reg[QUO_W-3:0], 2'd0};  qm_nxt = {qm_reg[QUO_W-3:0], 2'd3}; end
    endcase
  end

  // control
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      busy      <= 1'b0;
      cnt       <= '0;
      iter_done <= 1'b0;
    end else begin
      iter_done <= fix;                    // one pulse, 15 cycles after start
      if (load) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        if (cnt == CNT_W'(LATENCY-1)) busy <= 1'b0;   // falls with done
        cnt <= cnt + 1'b1;
      end
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    if (load) begin
      resid    <= {4'b0000, man_a};   // 4 * (x/8) = x/2
      dvsr     <= man_b;
      q_reg    <= '0;
      qm_reg   <= '1;                  // -1
      res.info <= info;
    end else if (step) begin
      resid  <= {w_nxt[RESID_W-3:0], 2'b00};   // next 4w, |w| < 2/3 so top bits are sign
      q_reg  <= q_nxt;
      qm_reg <= qm_nxt;
    end else if (fix) begin
      resid      <= resid_sel;
      res.quo    <= resid[RESID_W-1] ? qm_reg : q_reg;
      res.sticky <= |resid_sel;
    end
  end

endmodule

// File: srt_round_pack.sv
`timescale 1ns/100ps

module srt_round_pack (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   iter_done,
  input  srt_div_pkg::iter_res_s res,
  output srt_div_pkg::fp32_u     result,
  output srt_div_pkg::div_flags_s flags,
  output logic                   done
);
  import srt_div_pkg::*;

  logic                    lead;      // quotient >= 1
  logic [MAN_W-1:0]        mant;
  logic                    guard, sticky_all, round_up;
  logic [MAN_W:0]          mant_r;    // with rounding carry
  logic signed [EXP_W-1:0] exp_n, exp_r;
  fp32_u                   word_c;
  div_flags_s              flags_c;

  assign lead = res.quo[MAN_W+1];   // weight 2^0 of quo / 2^25

  // normalize to 24 bits plus guard
  always_comb begin
    if (lead) begin
      mant       = res.quo[MAN_W+1 -: MAN_W];
      guard      = res.quo[1];
      sticky_all = res.quo[0] | res.sticky;
      exp_n      = res.info.exp_base;
    end else begin
      mant       = res.quo[MAN_W -: MAN_W];   // one left
      guard      = res.quo[0];
      sticky_all = res.sticky;
      exp_n      = res.info.exp_base - EXP_W'(1);
    end
  end

  // nearest even
  assign round_up = guard & (sticky_all | mant[0]);
  assign mant_r   = {1'b0, mant} + (MAN_W+1)'(round_up);
  assign exp_r    = mant_r[MAN_W] ? exp_n + EXP_W'(1) : exp_n;   // 1.111.. -> 10.000..

  always_comb begin
    word_c  = '0;
    flags_c = '0;
    word_c.f.sign = res.info.sign;
    flags_c.inexact = guard | sticky_all;
    if (exp_r >= EXP_MAX) begin
      word_c.f.exp     = 8'hff;        // inf
      flags_c.overflow = 1'b1;
      flags_c.inexact  = 1'b1;
    end else if (exp_r <= EXP_W'(0)) begin
      flags_c.underflow = 1'b1;        // flush to signed zero
      flags_c.inexact   = 1'b1;
    end else begin
      word_c.f.exp  = exp_r[7:0];
      word_c.f.frac = mant_r[MAN_W-2:0];   // zero after a rounding carry
    end

    // specials replace the word and keep only the early flags
    case (res.info.special)
      SP_NAN: begin
        word_c.word = QNAN;
        flags_c     = res.info.early;
      end
      SP_INF: begin
        word_c.f.exp  = 8'hff;
        word_c.f.frac = '0;
        flags_c       = res.info.early;
      end
      SP_ZERO: begin
        word_c.f.exp  = 8'h00;
        word_c.f.frac = '0;
        flags_c       = res.info.early;
      end
      default: flags_c = flags_c | res.info.early;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      result <= '0;
      flags  <= '0;
      done   <= 1'b0;
    end else begin
      done <= iter_done;      // one cycle after the correction edge
      if (iter_done) begin
        result <= word_c;     // held until next done
        flags  <= flags_c;
      end
    end
  end

endmodule

// File: srt_div_fp32.sv
`timescale 1ns/100ps

module srt_div_fp32 (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start,
  input  srt_div_pkg::fp32_u      a,       // dividend
  input  srt_div_pkg::fp32_u      b,       // divisor
  output srt_div_pkg::fp32_u      result,
  output srt_div_pkg::div_flags_s flags,
  output logic                    done,
  output logic                    busy
);
  import srt_div_pkg::*;

  op_info_s         info;       // comb, sampled on the accepting edge
  logic [MAN_W-1:0] man_a;
  logic [MAN_W-1:0] man_b;
  iter_res_s        ires;       // registered quotient + sticky + info
  logic             iter_done;

  // classify operands, form exponent and significands
  srt_unpack u_unpack (
    .a     (a),
    .b     (b),
    .info  (info),
    .man_a (man_a),
    .man_b (man_b)
  );

  // radix-4 recurrence, 14 steps + correction
  srt_iter u_iter (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .info      (info),
    .man_a     (man_a),
    .man_b     (man_b),
    .busy      (busy),
    .res       (ires),
    .iter_done (iter_done)
  );

  // normalize, round, pack, one more cycle
  srt_round_pack u_round_pack (
    .clk       (clk),
    .rst       (rst),
    .iter_done (iter_done),
    .res       (ires),
    .result    (result),
    .flags     (flags),
    .done      (done)
  );

endmodule

// File: srt_div_fp32_chk.sv
`timescale 1ns/100ps

module srt_div_fp32_chk (
  input logic clk,
  input logic rst,
  input logic start,
  input logic busy,
  input logic done
);
  import srt_div_pkg::*;

  logic accept;
  logic pending;   // accepted op still waiting for its done

  assign accept = start & ~busy;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) pending <= 1'b0;
    else if (accept) pending <= 1'b1;   // back to back start wins over done
    else if (done) pending <= 1'b0;
  end

  done_one_cycle: assert property (@(posedge clk) disable iff (!rst) done |=> !done)
    else $error("done held longer than one cycle");

  // done register set on edge LATENCY, sampled one tick later
  done_latency: assert property (@(posedge clk) disable iff (!rst)
    accept |-> ##(LATENCY+1) done)
    else $error("done not seen LATENCY cycles after accepted start");

  busy_window: assert property (@(posedge clk) disable iff (!rst)
    accept |=> busy [*LATENCY])
    else $error("busy dropped while a division was running");

  no_orphan_done: assert property (@(posedge clk) disable iff (!rst) done |-> pending)
    else $error("done without an accepted start");

endmodule

bind srt_div_fp32 srt_div_fp32_chk u_chk (
  .clk   (clk),
  .rst   (rst),
  .start (start),
  .busy  (busy),
  .done  (done)
);

// File: tb_srt_div_fp32.sv
`timescale 1ns/100ps

module tb_srt_div_fp32;
  import srt_div_pkg::*;

  typedef struct packed {
    logic [31:0] word;       // expected result word
    div_flags_s  flg;
    logic [31:0] start_cyc;  // cyc value right after the accepting edge
  } expect_s;

  logic        clk;
  logic        rst;
  logic        start;
  fp32_u       a;
  fp32_u       b;
  fp32_u       result;
  div_flags_s  flags;
  logic        done;
  logic        busy;

  logic [31:0] cyc;          // posedges seen
  logic [31:0] lfsr_state;
  expect_s     exp_q[$];     // issued, not yet compared
  int          n_issued;
  int          n_checked;

  srt_div_fp32 DUT (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .a      (a),
    .b      (b),
    .result (result),
    .flags  (flags),
    .done   (done),
    .busy   (busy)
  );

  always #5 clk = ~clk;   // 10 ns period

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic fail_run(input string why);
    if (why.len() > 0) $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("ERR %s got %h expected %h at %0t", name, got, want, $time);
      fail_run("");
    end
  endtask

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h8020_0003;
    else return s >> 1;
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};   // one step per bit
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic rand_normal(output logic [31:0] w);
    logic [31:0] s, e, f;
    rand_bits(1, s);
    rand_bits(6, e);
    rand_bits(23, f);
    w = {s[0], 8'd96 + e[7:0], f[22:0]};   // exp 96..159 keeps quotients in range
  endtask

  function automatic div_flags_s flag_set(input logic inv, dbz, ovf, unf, inx);
    flag_set = {inv, dbz, ovf, unf, inx};
  endfunction

  // expected word and flags, long division on the significands
  function automatic expect_s fp32_div_ref(input logic [31:0] x, input logic [31:0] y);
    expect_s     r;
    logic        x_nan, x_inf, x_zero, y_nan, y_inf, y_zero, sgn;
    logic [49:0] num, quo, rem;
    logic [23:0] mant;
    logic [24:0] mant_r;
    logic        guard, sticky;
    int          e;
    r      = '0;
    x_nan  = (x[30:23] == 8'hff) && (x[22:0] != 0);
    x_inf  = (x[30:23] == 8'hff) && (x[22:0] == 0);
    x_zero = (x[30:23] == 8'h00);   // subnormal reads as zero
    y_nan  = (y[30:23] == 8'hff) && (y[22:0] != 0);
    y_inf  = (y[30:23] == 8'hff) && (y[22:0] == 0);
    y_zero = (y[30:23] == 8'h00);
    sgn    = x[31] ^ y[31];
    if (x_nan || y_nan) begin
      r.word = QNAN;
    end else if ((x_zero && y_zero) || (x_inf && y_inf)) begin
      r.word        = QNAN;
      r.flg.invalid = 1'b1;
    end else if (x_inf) begin
      r.word = {sgn, 8'hff, 23'd0};
    end else if (y_zero) begin
      r.word            = {sgn, 8'hff, 23'd0};
      r.flg.div_by_zero = 1'b1;
    end else if (x_zero || y_inf) begin
      r.word = {sgn, 31'd0};
    end else begin
      num = 50'({1'b1, x[22:0]}) << 26;
      quo = num / {26'd0, 1'b1, y[22:0]};   // ratio * 2^26
      rem = num % {26'd0, 1'b1, y[22:0]};
      e   = int'(x[30:23]) - int'(y[30:23]) + 127;
      if (quo[26]) begin
        mant   = quo[26:3];
        guard  = quo[2];
        sticky = (quo[1:0] != 0) || (rem != 0);
      end else begin
        mant   = quo[25:2];   // ratio below one
        guard  = quo[1];
        sticky = quo[0] || (rem != 0);
        e      = e - 1;
      end
      mant_r = {1'b0, mant} + 25'(guard & (sticky | mant[0]));
      if (mant_r[24]) e = e + 1;
      r.flg.inexact = guard | sticky;
      if (e >= 255) begin
        r.word         = {sgn, 8'hff, 23'd0};
        r.flg.overflow = 1'b1;
        r.flg.inexact  = 1'b1;
      end else if (e <= 0) begin
        r.word          = {sgn, 31'd0};   // flushed
        r.flg.underflow = 1'b1;
        r.flg.inexact   = 1'b1;
      end else begin
        r.word = {sgn, 8'(e), mant_r[22:0]};
      end
    end
    return r;
  endfunction

  // called 1 ns after a rising edge
  task automatic wait_idle();
    int n;
    n = 0;
    while (busy) begin
      @(posedge clk);
      #1;
      n++;
      if (n > 4 * LATENCY) fail_run("busy stayed high, divider never went idle");
    end
  endtask

  task automatic issue_op(input logic [31:0] x, input logic [31:0] y, input expect_s e);
    wait_idle();
    a.word      = x;
    b.word      = y;
    start       = 1'b1;
    e.start_cyc = cyc + 1;
    exp_q.push_back(e);
    n_issued++;
    @(posedge clk);
    #1;
    start  = 1'b0;
    a.word = ~x;   // operands only matter in the start cycle
    b.word = ~y;
  endtask

  task automatic issue_ref(input logic [31:0] x, input logic [31:0] y);
    issue_op(x, y, fp32_div_ref(x, y));
  endtask

  task automatic issue_exp(input logic [31:0] x, input logic [31:0] y,
                           input logic [31:0] w, input div_flags_s f);
    expect_s e;
    e      = '0;
    e.word = w;
    e.flg  = f;
    issue_op(x, y, e);
  endtask

  initial begin : driver
    logic [31:0] x, y;
    div_flags_s  none;
    int          i;
    int          guard;
    clk        = 1'b0;
    rst        = 1'b0;
    start      = 1'b0;
    a.word     = '0;
    b.word     = '0;
    cyc        = '0;
    n_issued   = 0;
    n_checked  = 0;
    lfsr_state = 32'd59;
    none       = '0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b1;
    repeat (10) @(posedge clk);   // idle window, compare process watches busy and done
    #1;

    // exact quotients
    issue_exp(32'h3f80_0000, 32'h3f80_0000, 32'h3f80_0000, none);   // 1/1
    issue_exp(32'h4100_0000, 32'h4000_0000, 32'h4080_0000, none);   // 8/2
    issue_exp(32'h3e80_0000, 32'h4080_0000, 32'h3d80_0000, none);   // 0.25/4
    issue_exp(32'hc000_0000, 32'h3e80_0000, 32'hc100_0000, none);   // -2/0.25
    issue_exp(32'h40c0_0000, 32'h4040_0000, 32'h4000_0000, none);   // 6/3
    issue_exp(32'hc110_0000, 32'h4040_0000, 32'hc040_0000, none);   // -9/3
    for (i = 0; i < 4; i++) begin
      rand_normal(x);
      issue_exp(x, x, 32'h3f80_0000, none);
    end

    for (i = 0; i < 2000; i++) begin
      rand_normal(x);
      rand_normal(y);
      issue_ref(x, y);
    end

    // special operands
    issue_exp(32'h0000_0000, 32'h0000_0000, QNAN, flag_set(1, 0, 0, 0, 0));
    issue_exp(32'h7f80_0000, 32'hff80_0000, QNAN, flag_set(1, 0, 0, 0, 0));
    issue_exp(32'h4040_0000, 32'h0000_0000, 32'h7f80_0000, flag_set(0, 1, 0, 0, 0));
    issue_exp(32'hc040_0000, 32'h0000_0000, 32'hff80_0000, flag_set(0, 1, 0, 0, 0));
    issue_exp(32'h0000_0000, 32'hc040_0000, 32'h8000_0000, none);
    issue_exp(32'hc040_0000, 32'h7f80_0000, 32'h8000_0000, none);
    issue_exp(32'h7fc0_0001, 32'h3f80_0000, QNAN, none);
    issue_exp(32'h4040_0000, 32'hffc0_0000, QNAN, none);
    issue_exp(32'hff80_0000, 32'h4000_0000, 32'hff80_0000, none);
    issue_exp(32'h0000_0001, 32'h3f80_0000, 32'h0000_0000, none);   // subnormal dividend
    issue_exp(32'h4040_0000, 32'h8000_0010, 32'hff80_0000, flag_set(0, 1, 0, 0, 0));

    // range limits
    issue_exp(32'h7f00_0000, 32'h0080_0000, 32'h7f80_0000, flag_set(0, 0, 1, 0, 1));
    issue_exp(32'hff00_0000, 32'h0080_0000, 32'hff80_0000, flag_set(0, 0, 1, 0, 1));
    issue_exp(32'h0080_0000, 32'h7f00_0000, 32'h0000_0000, flag_set(0, 0, 0, 1, 1));

    // second start while busy, must be dropped
    rand_normal(x);
    rand_normal(y);
    issue_ref(x, y);
    repeat (4) @(posedge clk);
    #1;
    a.word = 32'h4049_0fdb;
    b.word = 32'h3f80_0000;
    start  = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    rand_normal(x);
    issue_ref(x, 32'h4040_0000);   // follows right after that done

    guard = 0;
    while (exp_q.size() != 0 || busy) begin
      @(posedge clk);
      guard++;
      if (guard > 4 * LATENCY) fail_run("operations still pending at end of run");
    end
    repeat (2 * LATENCY) @(posedge clk);   // catch any stray done
    if (n_checked == n_issued) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      fail_run("number of results differs from number of operations");
    end
  end

  // outputs sampled on the falling edge, away from register updates
  initial begin : compare
    expect_s e;
    int      guard;
    guard = 0;
    while (rst !== 1'b1) begin
      @(negedge clk);
      guard++;
      if (guard > 100) fail_run("reset was never released");
    end
    forever begin
      @(negedge clk);
      if (done === 1'b1) begin
        if (exp_q.size() == 0) begin
          fail_run("done pulse with no operation pending");
        end else begin
          e = exp_q.pop_front();
          check_val("done_latency", cyc - e.start_cyc, 32'(LATENCY));
          check_val("result", result.word, e.word);
          check_val("flags", 32'(flags), 32'(e.flg));
          n_checked++;
        end
      end else if (exp_q.size() != 0) begin
        if (cyc >= exp_q[0].start_cyc) begin
          if (cyc - exp_q[0].start_cyc >= LATENCY) begin
            fail_run("timeout, done missing after an accepted start");
          end else begin
            check_val("busy", 32'(busy), 32'h1);
          end
        end
      end else begin
        check_val("busy", 32'(busy), 32'h0);   // nothing in flight
      end
    end
  end

endmodule

// File: compile.f
srt_div_pkg.sv
srt_unpack.sv
srt_qds.sv
srt_iter.sv
srt_round_pack.sv
srt_div_fp32.sv
srt_div_fp32_chk.sv
tb_srt_div_fp32.sv

// File: Bender.yml
package:
  name: srt_div_fp32

sources:
  - srt_div_pkg.sv
  - srt_unpack.sv
  - srt_qds.sv
  - srt_iter.sv
  - srt_round_pack.sv
  - srt_div_fp32.sv
  - target: test
    files:
      - srt_div_fp32_chk.sv
      - tb_srt_div_fp32.sv
